//--- leaf_depacketizer.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_depacketizer import leaf_pkg::*; #(
    parameter int leaf_id = 3
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [packet_bits-1:0]   pkt_in,
    output logic [num_in_ports-1:0] in_we,
    output logic [payload_bits-1:0] in_data,
    output logic                    cfg_we,
    output logic                    cfg_sel,
    output logic [payload_bits-1:0] cfg_data
);

    logic                    hit;
    logic [port_bits-1:0]    port;
    logic [payload_bits-1:0] payload_q;

    // only packets for this leaf are taken
    assign hit  = pkt_in[valid_pos] &&
                  (pkt_in[leaf_lo +: leaf_bits] == leaf_bits'(leaf_id));
    assign port = pkt_in[port_lo +: port_bits];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_we  <= '0;
            cfg_we <= 1'b0;
        end else begin
            in_we  <= '0;
            cfg_we <= 1'b0;
            if (hit) begin
                if (port == port_bits'(cfg_port)) begin
                    cfg_we <= 1'b1;
                end
                // ports 1..4 feed the input FIFOs, anything else is dropped
                for (int i = 0; i < num_in_ports; i++) begin
                    if (port == port_bits'(i + 1)) begin
                        in_we[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        payload_q <= pkt_in[payload_lo +: payload_bits];
    end

    assign in_data  = payload_q;
    assign cfg_data = payload_q;
    assign cfg_sel  = payload_q[cfg_sel_bit];

endmodule

`default_nettype wire

//--- leaf_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_fifo #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 16
) (
    input  wire    clk,
    input  wire    rst_n,
    input  wire    wr_en,
    input  entry_t wr_data,
    input  wire    rd_en,
    output entry_t rd_data,
    output logic   empty,
    output logic   full
);

    localparam int addr_bits  = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_bits = $clog2(depth + 1);

    entry_t                mem [depth];
    logic [addr_bits-1:0]  wr_ptr;
    logic [addr_bits-1:0]  rd_ptr;
    logic [count_bits-1:0] count;
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty   = (count == '0);
    assign full    = (count == count_bits'(depth));
    // show-ahead, head entry always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == addr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == addr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- leaf_i4o2.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_i4o2 import leaf_pkg::*; #(
    parameter int leaf_id    = 3,
    parameter int fifo_depth = 16
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    ap_start,
    input  wire                    resend,
    input  wire [packet_bits-1:0]  din_leaf_bft2interface,
    output logic [packet_bits-1:0] dout_leaf_interface2bft
);

    logic [payload_bits-1:0] d2u_1, d2u_2, d2u_3, d2u_4;
    logic                    vld_i2u_1, vld_i2u_2, vld_i2u_3, vld_i2u_4;
    logic                    ack_u2i_1, ack_u2i_2, ack_u2i_3, ack_u2i_4;
    logic [payload_bits-1:0] u2d_1, u2d_2;
    logic                    vld_u2i_1, vld_u2i_2;
    logic                    ack_i2u_1, ack_i2u_2;
    logic                    reset_ap_start_user;
    logic [packet_bits-1:0]  pkt_raw;

    // nothing leaves toward the tree during resend
    assign dout_leaf_interface2bft = resend ? '0 : pkt_raw;

    leaf_interface #(
        .leaf_id    (leaf_id),
        .fifo_depth (fifo_depth)
    ) u_leaf_interface (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .ap_start                   (ap_start),
        .resend                     (resend),
        .din_leaf_bft2interface     (din_leaf_bft2interface),
        .dout_leaf_interface2bft    (pkt_raw),
        .dout_leaf_interface2user_1 (d2u_1),
        .dout_leaf_interface2user_2 (d2u_2),
        .dout_leaf_interface2user_3 (d2u_3),
        .dout_leaf_interface2user_4 (d2u_4),
        .vld_interface2user_1       (vld_i2u_1),
        .vld_interface2user_2       (vld_i2u_2),
        .vld_interface2user_3       (vld_i2u_3),
        .vld_interface2user_4       (vld_i2u_4),
        .ack_user2interface_1       (ack_u2i_1),
        .ack_user2interface_2       (ack_u2i_2),
        .ack_user2interface_3       (ack_u2i_3),
        .ack_user2interface_4       (ack_u2i_4),
        .din_leaf_user2interface_1  (u2d_1),
        .din_leaf_user2interface_2  (u2d_2),
        .vld_user2interface_1       (vld_u2i_1),
        .vld_user2interface_2       (vld_u2i_2),
        .ack_interface2user_1       (ack_i2u_1),
        .ack_interface2user_2       (ack_i2u_2),
        .reset_ap_start_user        (reset_ap_start_user)
    );

    user_kernel u_user_kernel (
        .clk                        (clk),
        .rst_n                      (reset_ap_start_user),
        .dout_leaf_interface2user_1 (d2u_1),
        .dout_leaf_interface2user_2 (d2u_2),
        .dout_leaf_interface2user_3 (d2u_3),
        .dout_leaf_interface2user_4 (d2u_4),
        .vld_interface2user_1       (vld_i2u_1),
        .vld_interface2user_2       (vld_i2u_2),
        .vld_interface2user_3       (vld_i2u_3),
        .vld_interface2user_4       (vld_i2u_4),
        .ack_user2interface_1       (ack_u2i_1),
        .ack_user2interface_2       (ack_u2i_2),
        .ack_user2interface_3       (ack_u2i_3),
        .ack_user2interface_4       (ack_u2i_4),
        .din_leaf_user2interface_1  (u2d_1),
        .din_leaf_user2interface_2  (u2d_2),
        .vld_user2interface_1       (vld_u2i_1),
        .vld_user2interface_2       (vld_u2i_2),
        .ack_interface2user_1       (ack_i2u_1),
        .ack_interface2user_2       (ack_i2u_2)
    );

endmodule

`default_nettype wire

//--- leaf_interface.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_interface import leaf_pkg::*; #(
    parameter int leaf_id    = 3,
    parameter int fifo_depth = 16
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     ap_start,
    input  wire                     resend,
    input  wire [packet_bits-1:0]   din_leaf_bft2interface,
    output logic [packet_bits-1:0]  dout_leaf_interface2bft,
    output logic [payload_bits-1:0] dout_leaf_interface2user_1,
    output logic [payload_bits-1:0] dout_leaf_interface2user_2,
    output logic [payload_bits-1:0] dout_leaf_interface2user_3,
    output logic [payload_bits-1:0] dout_leaf_interface2user_4,
    output logic                    vld_interface2user_1,
    output logic                    vld_interface2user_2,
    output logic                    vld_interface2user_3,
    output logic                    vld_interface2user_4,
    input  wire                     ack_user2interface_1,
    input  wire                     ack_user2interface_2,
    input  wire                     ack_user2interface_3,
    input  wire                     ack_user2interface_4,
    input  wire [payload_bits-1:0]  din_leaf_user2interface_1,
    input  wire [payload_bits-1:0]  din_leaf_user2interface_2,
    input  wire                     vld_user2interface_1,
    input  wire                     vld_user2interface_2,
    output logic                    ack_interface2user_1,
    output logic                    ack_interface2user_2,
    output logic                    reset_ap_start_user
);

    logic [num_in_ports-1:0]  in_we;
    logic [num_in_ports-1:0]  in_rd;
    logic [num_in_ports-1:0]  in_empty;
    logic [payload_bits-1:0]  in_data;
    logic [payload_bits-1:0]  in_q [num_in_ports];
    logic                     cfg_we;
    logic                     cfg_sel;
    logic [payload_bits-1:0]  cfg_data;
    logic [leaf_bits-1:0]     dest_leaf_1;
    logic [leaf_bits-1:0]     dest_leaf_2;
    logic [port_bits-1:0]     dest_port_1;
    logic [port_bits-1:0]     dest_port_2;
    logic [num_out_ports-1:0] out_rd;
    logic [payload_bits-1:0]  out_q_1;
    logic [payload_bits-1:0]  out_q_2;
    logic                     out_empty_1;
    logic                     out_empty_2;
    logic                     out_full_1;
    logic                     out_full_2;

    leaf_depacketizer #(
        .leaf_id (leaf_id)
    ) u_depacketizer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pkt_in   (din_leaf_bft2interface),
        .in_we    (in_we),
        .in_data  (in_data),
        .cfg_we   (cfg_we),
        .cfg_sel  (cfg_sel),
        .cfg_data (cfg_data)
    );

    // ************************************************************************
    // input side, one FIFO per user port
    // ************************************************************************
    for (genvar i = 0; i < num_in_ports; i++) begin : g_in_fifo
        leaf_fifo #(
            .entry_t (logic [payload_bits-1:0]),
            .depth   (fifo_depth)
        ) u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (in_we[i]),
            .wr_data (in_data),
            .rd_en   (in_rd[i]),
            .rd_data (in_q[i]),
            .empty   (in_empty[i]),
            .full    ()
        );
    end

    assign in_rd = {ack_user2interface_4, ack_user2interface_3,
                    ack_user2interface_2, ack_user2interface_1} & ~in_empty;

    assign vld_interface2user_1 = !in_empty[0];
    assign vld_interface2user_2 = !in_empty[1];
    assign vld_interface2user_3 = !in_empty[2];
    assign vld_interface2user_4 = !in_empty[3];

    assign dout_leaf_interface2user_1 = in_q[0];
    assign dout_leaf_interface2user_2 = in_q[1];
    assign dout_leaf_interface2user_3 = in_q[2];
    assign dout_leaf_interface2user_4 = in_q[3];

    leaf_route_table u_route_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we      (cfg_we),
        .cfg_sel     (cfg_sel),
        .cfg_data    (cfg_data),
        .dest_leaf_1 (dest_leaf_1),
        .dest_leaf_2 (dest_leaf_2),
        .dest_port_1 (dest_port_1),
        .dest_port_2 (dest_port_2)
    );

    // ************************************************************************
    // output side, kernel results waiting for the packetizer
    // ************************************************************************
    assign ack_interface2user_1 = !out_full_1;
    assign ack_interface2user_2 = !out_full_2;

    leaf_fifo #(
        .entry_t (logic [payload_bits-1:0]),
        .depth   (fifo_depth)
    ) u_out_fifo_1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (vld_user2interface_1 && ack_interface2user_1),
        .wr_data (din_leaf_user2interface_1),
        .rd_en   (out_rd[0]),
        .rd_data (out_q_1),
        .empty   (out_empty_1),
        .full    (out_full_1)
    );

    leaf_fifo #(
        .entry_t (logic [payload_bits-1:0]),
        .depth   (fifo_depth)
    ) u_out_fifo_2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (vld_user2interface_2 && ack_interface2user_2),
        .wr_data (din_leaf_user2interface_2),
        .rd_en   (out_rd[1]),
        .rd_data (out_q_2),
        .empty   (out_empty_2),
        .full    (out_full_2)
    );

    leaf_packetizer u_packetizer (
        .clk         (clk),
        .rst_n       (rst_n),
        .resend      (resend),
        .out_data_1  (out_q_1),
        .out_data_2  (out_q_2),
        .out_empty_1 (out_empty_1),
        .out_empty_2 (out_empty_2),
        .out_rd      (out_rd),
        .dest_leaf_1 (dest_leaf_1),
        .dest_leaf_2 (dest_leaf_2),
        .dest_port_1 (dest_port_1),
        .dest_port_2 (dest_port_2),
        .pkt_out     (dout_leaf_interface2bft)
    );

    // kernel stays in reset until ap_start, then never again
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reset_ap_start_user <= 1'b0;
        end else if (ap_start) begin
            reset_ap_start_user <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- leaf_packetizer.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_packetizer import leaf_pkg::*; (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      resend,
    input  wire [payload_bits-1:0]   out_data_1,
    input  wire [payload_bits-1:0]   out_data_2,
    input  wire                      out_empty_1,
    input  wire                      out_empty_2,
    output logic [num_out_ports-1:0] out_rd,
    input  wire [leaf_bits-1:0]      dest_leaf_1,
    input  wire [leaf_bits-1:0]      dest_leaf_2,
    input  wire [port_bits-1:0]      dest_port_1,
    input  wire [port_bits-1:0]      dest_port_2,
    output logic [packet_bits-1:0]   pkt_out
);

    logic                   take;
    logic                   sel_2;
    logic                   last_1;
    logic [seq_bits-1:0]    seq_1;
    logic [seq_bits-1:0]    seq_2;
    logic [packet_bits-1:0] pkt_next;

    // ************************************************************************
    // round-robin pick, held off completely during resend
    // ************************************************************************
    always_comb begin
        take  = 1'b0;
        sel_2 = 1'b0;
        if (!resend) begin
            if (!out_empty_2 && (last_1 || out_empty_1)) begin
                take  = 1'b1;
                sel_2 = 1'b1;
            end else if (!out_empty_1) begin
                take = 1'b1;
            end
        end
    end

    assign out_rd = {take && sel_2, take && !sel_2};

    always_comb begin
        pkt_next                               = '0;
        pkt_next[valid_pos]                    = 1'b1;
        pkt_next[leaf_lo +: leaf_bits]         = sel_2 ? dest_leaf_2 : dest_leaf_1;
        pkt_next[port_lo +: port_bits]         = sel_2 ? dest_port_2 : dest_port_1;
        pkt_next[seq_lo +: seq_bits]           = sel_2 ? seq_2 : seq_1;
        pkt_next[payload_lo +: payload_bits]   = sel_2 ? out_data_2 : out_data_1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_out <= '0;
            last_1  <= 1'b0;
            seq_1   <= '0;
            seq_2   <= '0;
        end else begin
            pkt_out <= take ? pkt_next : '0;
            if (take) begin
                last_1 <= !sel_2;
                // sequence counts wrap per output port
                if (sel_2) begin
                    seq_2 <= seq_2 + 1'b1;
                end else begin
                    seq_1 <= seq_1 + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    // ************************************************************************
    // tree packet layout
    // ************************************************************************
    localparam int packet_bits  = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int seq_bits     = 7;

    localparam int valid_pos  = 48;
    localparam int leaf_lo    = 43;
    localparam int port_lo    = 39;
    localparam int seq_lo     = 32;
    localparam int payload_lo = 0;

    localparam int num_in_ports  = 4;
    localparam int num_out_ports = 2;

    // ************************************************************************
    // configuration packets
    // ************************************************************************
    localparam int cfg_port    = 0;
    // 0 picks output 1, 1 picks output 2
    localparam int cfg_sel_bit = 0;
    localparam int cfg_leaf_lo = 8;
    localparam int cfg_port_lo = 16;

endpackage

`default_nettype wire

//--- leaf_route_table.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_route_table import leaf_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     cfg_we,
    input  wire                     cfg_sel,
    input  wire [payload_bits-1:0]  cfg_data,
    output logic [leaf_bits-1:0]    dest_leaf_1,
    output logic [leaf_bits-1:0]    dest_leaf_2,
    output logic [port_bits-1:0]    dest_port_1,
    output logic [port_bits-1:0]    dest_port_2
);

    logic [leaf_bits-1:0] new_leaf;
    logic [port_bits-1:0] new_port;

    assign new_leaf = cfg_data[cfg_leaf_lo +: leaf_bits];
    assign new_port = cfg_data[cfg_port_lo +: port_bits];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dest_leaf_1 <= '0;
            dest_leaf_2 <= '0;
            dest_port_1 <= '0;
            dest_port_2 <= '0;
        end else if (cfg_we) begin
            if (cfg_sel) begin
                dest_leaf_2 <= new_leaf;
                dest_port_2 <= new_port;
            end else begin
                dest_leaf_1 <= new_leaf;
                dest_port_1 <= new_port;
            end
        end
    end

endmodule

`default_nettype wire

//--- leaf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_tb import leaf_pkg::*; ();

    localparam int tb_leaf_id  = 3;
    localparam int max_rows    = 160;
    localparam int max_results = 64;
    localparam logic [packet_bits-1:0] zero_pkt = '0;

    logic                   clk;
    logic                   rst_n;
    logic                   ap_start;
    logic                   resend;
    logic [packet_bits-1:0] din;
    logic [packet_bits-1:0] dout;

    // ************************************************************************
    // stimulus table, one row per clock cycle
    // ************************************************************************
    logic [packet_bits-1:0] row_pkt    [max_rows];
    logic                   row_start  [max_rows];
    logic                   row_resend [max_rows];
    int                     n_rows;
    logic                   cur_start;
    logic                   cur_resend;

    // predicted packets per output port, in arrival order
    logic [packet_bits-1:0] exp_pkt    [num_out_ports][max_results];
    int                     exp_count  [num_out_ports];
    int                     exp_next   [num_out_ports];
    int                     exp_seq    [num_out_ports];
    int                     route_leaf [num_out_ports];
    int                     route_port [num_out_ports];

    logic [31:0] lcg_state;
    int          cycle_count;
    int          cycle_limit;

    leaf_i4o2 #(
        .leaf_id    (tb_leaf_id),
        .fifo_depth (16)
    ) UUT (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .ap_start                (ap_start),
        .resend                  (resend),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [packet_bits-1:0] make_pkt(input int leaf, input int port,
                                                        input int seq,
                                                        input logic [payload_bits-1:0] payload);
        logic [packet_bits-1:0] pkt;
        pkt                                = '0;
        pkt[valid_pos]                     = 1'b1;
        pkt[leaf_lo +: leaf_bits]          = leaf_bits'(leaf);
        pkt[port_lo +: port_bits]          = port_bits'(port);
        pkt[seq_lo +: seq_bits]            = seq_bits'(seq);
        pkt[payload_lo +: payload_bits]    = payload;
        return pkt;
    endfunction

    task automatic check_value(input string what, input logic [packet_bits-1:0] got,
                               input logic [packet_bits-1:0] expected);
        if (got !== expected) begin
            $display("Error at %0d ns: %s, got %h, expected %h", $time, what, got, expected);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic add_row(input logic [packet_bits-1:0] pkt);
        row_pkt[n_rows]    = pkt;
        row_start[n_rows]  = cur_start;
        row_resend[n_rows] = cur_resend;
        n_rows++;
    endtask

    task automatic add_idle(input int n);
        repeat (n) add_row(zero_pkt);
    endtask

    // sel 0 is output 1, sel 1 is output 2
    task automatic add_config(input int sel, input int leaf, input int port);
        logic [payload_bits-1:0] cfg;
        cfg = payload_bits'((port << cfg_port_lo) | (leaf << cfg_leaf_lo) | sel);
        add_row(make_pkt(tb_leaf_id, cfg_port, 0, cfg));
        route_leaf[sel] = leaf;
        route_port[sel] = port;
    endtask

    // lane 0 sums ports 1 and 2, lane 1 is port 3 minus port 4
    task automatic add_pair(input int lane);
        logic [payload_bits-1:0] a;
        logic [payload_bits-1:0] b;
        logic [payload_bits-1:0] result;
        a = lcg_next();
        b = lcg_next();
        add_row(make_pkt(tb_leaf_id, 2 * lane + 1, 0, a));
        add_row(make_pkt(tb_leaf_id, 2 * lane + 2, 0, b));
        result = (lane == 0) ? a + b : a - b;
        exp_pkt[lane][exp_count[lane]] = make_pkt(route_leaf[lane], route_port[lane],
                                                  exp_seq[lane], result);
        exp_seq[lane]++;
        exp_count[lane]++;
    endtask

    task automatic build_table();
        logic [packet_bits-1:0] bad;
        n_rows     = 0;
        cur_start  = 1'b0;
        cur_resend = 1'b0;
        lcg_state  = 32'hcfb4;
        for (int k = 0; k < num_out_ports; k++) begin
            exp_count[k]  = 0;
            exp_seq[k]    = 0;
            route_leaf[k] = 0;
            route_port[k] = 0;
        end
        // routes and a first batch of data arrive while the kernel is held in reset
        add_idle(6);
        add_config(0, 5, 1);
        add_config(1, 9, 2);
        add_pair(0);
        add_pair(1);
        add_idle(3);
        cur_start = 1'b1;
        add_idle(3);
        for (int i = 0; i < 4; i++) begin
            add_pair(0);
            add_pair(1);
        end
        // foreign leaves, unused ports, valid bit low
        add_row(make_pkt(4, 1, 0, lcg_next()));
        add_row(make_pkt(2, 3, 0, lcg_next()));
        add_row(make_pkt(tb_leaf_id, 5, 0, lcg_next()));
        add_row(make_pkt(tb_leaf_id, 12, 0, lcg_next()));
        bad            = make_pkt(tb_leaf_id, 1, 0, lcg_next());
        bad[valid_pos] = 1'b0;
        add_row(bad);
        add_pair(0);
        add_pair(1);
        add_idle(12);
        // results pile up in the output FIFOs
        cur_resend = 1'b1;
        add_idle(2);
        for (int i = 0; i < 3; i++) begin
            add_pair(0);
            add_pair(1);
        end
        add_idle(6);
        cur_resend = 1'b0;
        add_idle(12);
        // new route for output 1, its sequence count carries on
        add_config(0, 7, 5);
        add_idle(4);
        for (int i = 0; i < 3; i++) begin
            add_pair(0);
        end
        add_pair(1);
        add_pair(1);
        add_idle(10);
    endtask

    // ************************************************************************
    // output monitor, sampled mid-cycle
    // ************************************************************************
    always @(negedge clk) begin : monitor
        int idx;
        if (!rst_n) begin
            exp_next[0] = 0;
            exp_next[1] = 0;
        end else if (resend) begin
            check_value("tree output during resend", dout, zero_pkt);
        end else if (!dout[valid_pos]) begin
            check_value("idle tree output", dout, zero_pkt);
        end else begin
            // output 2 is the only route using port 2
            idx = (dout[port_lo +: port_bits] == 4'd2) ? 1 : 0;
            if (exp_next[idx] >= exp_count[idx]) begin
                $display("Unexpected packet %h on the tree output at %0d ns", dout, $time);
                $display("Test failures found");
                $fatal(1, "unexpected output packet");
            end else begin
                check_value("output packet", dout, exp_pkt[idx][exp_next[idx]]);
                exp_next[idx]++;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            cycle_count = 0;
        end else begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("Test failures found");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        ap_start = 1'b0;
        resend   = 1'b0;
        din      = '0;
        build_table();
        cycle_limit = 2 * n_rows + 200;
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            din      = row_pkt[r];
            ap_start = row_start[r];
            resend   = row_resend[r];
            @(posedge clk);
            #5;
        end
        din    = '0;
        resend = 1'b0;
        while (exp_next[0] < exp_count[0] || exp_next[1] < exp_count[1]) begin
            @(posedge clk);
        end
        // catch any stray packet
        repeat (20) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
leaf_pkg.sv
leaf_fifo.sv
leaf_depacketizer.sv
leaf_route_table.sv
leaf_packetizer.sv
leaf_interface.sv
user_kernel.sv
leaf_i4o2.sv
leaf_tb.sv

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module leaf_tb -f project.f -o leaf_sim

# the simulator exits non-zero on a fatal error, tee keeps the log going
./obj_dir/leaf_sim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"

//--- user_kernel.sv
`timescale 1ns/1ps
`default_nettype none

module user_kernel import leaf_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [payload_bits-1:0]  dout_leaf_interface2user_1,
    input  wire [payload_bits-1:0]  dout_leaf_interface2user_2,
    input  wire [payload_bits-1:0]  dout_leaf_interface2user_3,
    input  wire [payload_bits-1:0]  dout_leaf_interface2user_4,
    input  wire                     vld_interface2user_1,
    input  wire                     vld_interface2user_2,
    input  wire                     vld_interface2user_3,
    input  wire                     vld_interface2user_4,
    output logic                    ack_user2interface_1,
    output logic                    ack_user2interface_2,
    output logic                    ack_user2interface_3,
    output logic                    ack_user2interface_4,
    output logic [payload_bits-1:0] din_leaf_user2interface_1,
    output logic [payload_bits-1:0] din_leaf_user2interface_2,
    output logic                    vld_user2interface_1,
    output logic                    vld_user2interface_2,
    input  wire                     ack_interface2user_1,
    input  wire                     ack_interface2user_2
);

    logic take_1;
    logic take_2;

    // take a pair when both are there and the result slot frees up
    // inputs stay queued while held in reset
    assign take_1 = rst_n && vld_interface2user_1 && vld_interface2user_2 &&
                    (!vld_user2interface_1 || ack_interface2user_1);
    assign take_2 = rst_n && vld_interface2user_3 && vld_interface2user_4 &&
                    (!vld_user2interface_2 || ack_interface2user_2);

    assign ack_user2interface_1 = take_1;
    assign ack_user2interface_2 = take_1;
    assign ack_user2interface_3 = take_2;
    assign ack_user2interface_4 = take_2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_user2interface_1 <= 1'b0;
            vld_user2interface_2 <= 1'b0;
        end else begin
            if (take_1) begin
                vld_user2interface_1 <= 1'b1;
            end else if (ack_interface2user_1) begin
                vld_user2interface_1 <= 1'b0;
            end
            if (take_2) begin
                vld_user2interface_2 <= 1'b1;
            end else if (ack_interface2user_2) begin
                vld_user2interface_2 <= 1'b0;
            end
        end
    end

    // lane 1 adds, lane 2 subtracts
    always_ff @(posedge clk) begin
        if (take_1) begin
            din_leaf_user2interface_1 <= dout_leaf_interface2user_1 + dout_leaf_interface2user_2;
        end
        if (take_2) begin
            din_leaf_user2interface_2 <= dout_leaf_interface2user_3 - dout_leaf_interface2user_4;
        end
    end

endmodule

`default_nettype wire
